/* common/float_pkg.sv */
/*
 * Shared definitions for the vector float adder
 *   Default binary layout widths (binary32)
 *   Element counter width
 *   Vector sequencer state encoding
 */

`default_nettype none

package float_pkg;

  ////////////////////////////////////////
  // Format widths
  ////////////////////////////////////////

  // Exponent field width
  localparam int exp_size_default = 8;

  // Stored mantissa width, hidden bit excluded
  localparam int mant_size_default = 23;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  // Element counter and SIZE_IN width
  localparam int count_size_default = 16;

  // Vector sequencer states
  typedef enum logic [1:0] {
    idle        = 2'd0,
    gather      = 2'd1,
    wait_result = 2'd2
  } seq_state_t;

endpackage : float_pkg

`default_nettype wire

/* scalar_float_adder/float_align_add.sv */
/*
 * Alignment and magnitude add for ordinary operands
 *   Unpack with hidden bit, zero-exponent operands as zero
 *   Right shift of the smaller mantissa, truncating
 */

`timescale 1ns/100ps
`default_nettype none

module float_align_add #(
  parameter int EXP_SIZE = float_pkg::exp_size_default,
  parameter int MANT_SIZE = float_pkg::mant_size_default,
  localparam int DATA_SIZE = EXP_SIZE + MANT_SIZE + 1
) (
  input  wire  [DATA_SIZE-1:0] a,
  input  wire  [DATA_SIZE-1:0] b,
  output logic [MANT_SIZE+1:0] sum_mag,
  output logic                 sum_sign,
  output logic [EXP_SIZE-1:0]  sum_exp,
  output logic                 a_zero,
  output logic                 b_zero
);

  ////////////////////////////////////////
  // Unpack
  ////////////////////////////////////////

  logic                a_sign;
  logic                b_sign;
  logic [EXP_SIZE-1:0] a_exp;
  logic [EXP_SIZE-1:0] b_exp;
  logic [MANT_SIZE:0]  a_man;
  logic [MANT_SIZE:0]  b_man;

  assign a_sign = a[DATA_SIZE-1];
  assign b_sign = b[DATA_SIZE-1];
  assign a_exp  = a[DATA_SIZE-2 -: EXP_SIZE];
  assign b_exp  = b[DATA_SIZE-2 -: EXP_SIZE];

  // No subnormals, zero field means zero
  assign a_zero = (a_exp == '0);
  assign b_zero = (b_exp == '0);

  // Hidden bit restored
  assign a_man = a_zero ? '0 : {1'b1, a[MANT_SIZE-1:0]};
  assign b_man = b_zero ? '0 : {1'b1, b[MANT_SIZE-1:0]};

  ////////////////////////////////////////
  // Align
  ////////////////////////////////////////

  logic                a_larger;
  logic                big_sign;
  logic [EXP_SIZE-1:0] big_exp;
  logic [EXP_SIZE-1:0] small_exp;
  logic [MANT_SIZE:0]  big_man;
  logic [MANT_SIZE:0]  small_man;
  logic [EXP_SIZE-1:0] exp_diff;
  logic [MANT_SIZE:0]  small_aligned;

  // Exponent first, mantissa breaks the tie
  assign a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_man >= b_man));

  assign big_sign  = a_larger ? a_sign : b_sign;
  assign big_exp   = a_larger ? a_exp : b_exp;
  assign small_exp = a_larger ? b_exp : a_exp;
  assign big_man   = a_larger ? a_man : b_man;
  assign small_man = a_larger ? b_man : a_man;

  assign exp_diff = big_exp - small_exp;

  // Shifted-out bits are lost
  assign small_aligned = small_man >> exp_diff;

  ////////////////////////////////////////
  // Add or subtract magnitudes
  ////////////////////////////////////////

  always_comb begin
    if (a_sign == b_sign) begin
      sum_mag = {1'b0, big_man} + {1'b0, small_aligned};
    end else begin
      // Never negative, big_man >= small_aligned
      sum_mag = {1'b0, big_man} - {1'b0, small_aligned};
    end
  end

  assign sum_sign = big_sign;
  assign sum_exp  = big_exp;

endmodule : float_align_add

`default_nettype wire

/* scalar_float_adder/float_special_case.sv */
/*
 * Special-value classifier
 *   NaN and infinity detection
 *   Canonical quiet NaN or signed infinity result
 */

`timescale 1ns/100ps
`default_nettype none

module float_special_case #(
  parameter int EXP_SIZE = float_pkg::exp_size_default,
  parameter int MANT_SIZE = float_pkg::mant_size_default,
  localparam int DATA_SIZE = EXP_SIZE + MANT_SIZE + 1
) (
  input  wire  [DATA_SIZE-1:0] a,
  input  wire  [DATA_SIZE-1:0] b,
  output logic                 special,
  output logic [DATA_SIZE-1:0] special_value
);

  // Sign 0, exponent all ones, top mantissa bit set
  localparam logic [DATA_SIZE-1:0] QNAN =
    {1'b0, {EXP_SIZE{1'b1}}, 1'b1, {(MANT_SIZE-1){1'b0}}};

  logic a_exp_ones;
  logic b_exp_ones;
  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;

  assign a_exp_ones = &a[DATA_SIZE-2 -: EXP_SIZE];
  assign b_exp_ones = &b[DATA_SIZE-2 -: EXP_SIZE];

  // Nonzero mantissa splits NaN from infinity
  assign a_nan = a_exp_ones & (|a[MANT_SIZE-1:0]);
  assign b_nan = b_exp_ones & (|b[MANT_SIZE-1:0]);
  assign a_inf = a_exp_ones & ~(|a[MANT_SIZE-1:0]);
  assign b_inf = b_exp_ones & ~(|b[MANT_SIZE-1:0]);

  always_comb begin
    special       = 1'b1;
    special_value = QNAN;
    if (a_nan || b_nan) begin
      special_value = QNAN;
    end else if (a_inf && b_inf && (a[DATA_SIZE-1] != b[DATA_SIZE-1])) begin
      // Opposite infinities cancel
      special_value = QNAN;
    end else if (a_inf) begin
      special_value = {a[DATA_SIZE-1], {EXP_SIZE{1'b1}}, {MANT_SIZE{1'b0}}};
    end else if (b_inf) begin
      special_value = {b[DATA_SIZE-1], {EXP_SIZE{1'b1}}, {MANT_SIZE{1'b0}}};
    end else begin
      special       = 1'b0;
      special_value = '0;
    end
  end

endmodule : float_special_case

`default_nettype wire

/* scalar_float_adder/float_normalize_select.sv */
/*
 * Normalisation and final result select
 *   Carry or leading-zero shift with exponent adjust
 *   Overflow, underflow and special override
 */

`timescale 1ns/100ps
`default_nettype none

module float_normalize_select #(
  parameter int EXP_SIZE = float_pkg::exp_size_default,
  parameter int MANT_SIZE = float_pkg::mant_size_default,
  localparam int DATA_SIZE = EXP_SIZE + MANT_SIZE + 1
) (
  input  wire  [MANT_SIZE+1:0] sum_mag,
  input  wire                  sum_sign,
  input  wire  [EXP_SIZE-1:0]  sum_exp,
  input  wire                  special,
  input  wire  [DATA_SIZE-1:0] special_value,
  output logic [DATA_SIZE-1:0] result
);

  localparam int SHIFT_W = $clog2(MANT_SIZE + 2);

  // Two extra bits hold the sign and the carry out of the exponent
  localparam logic signed [EXP_SIZE+1:0] EXP_ONE = 1;
  localparam logic signed [EXP_SIZE+1:0] EXP_MAX = {2'b00, {EXP_SIZE{1'b1}}};

  logic [SHIFT_W-1:0]           lz;
  logic signed [EXP_SIZE+1:0]   exp_ext;
  logic signed [EXP_SIZE+1:0]   lz_ext;
  logic signed [EXP_SIZE+1:0]   exp_adj;
  logic [MANT_SIZE+1:0]         norm_man;

  ////////////////////////////////////////
  // Leading zeros above the hidden bit
  ////////////////////////////////////////

  // Ascending scan, highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i <= MANT_SIZE; i++) begin
      if (sum_mag[i]) lz = SHIFT_W'(MANT_SIZE - i);
    end
  end

  assign exp_ext = {2'b00, sum_exp};
  assign lz_ext  = {{(EXP_SIZE+2-SHIFT_W){1'b0}}, lz};

  always_comb begin
    if (sum_mag[MANT_SIZE+1]) begin
      // Carry out, drop the low bit
      norm_man = sum_mag >> 1;
      exp_adj  = exp_ext + EXP_ONE;
    end else begin
      norm_man = sum_mag << lz;
      exp_adj  = exp_ext - lz_ext;
    end
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    if (special) begin
      result = special_value;
    end else if ((sum_mag == '0) || exp_adj[EXP_SIZE+1] || (exp_adj == '0)) begin
      // Exact zero or underflow, always +0
      result = '0;
    end else if (exp_adj >= EXP_MAX) begin
      result = {sum_sign, {EXP_SIZE{1'b1}}, {MANT_SIZE{1'b0}}};
    end else begin
      result = {sum_sign, exp_adj[EXP_SIZE-1:0], norm_man[MANT_SIZE-1:0]};
    end
  end

endmodule : float_normalize_select

`default_nettype wire

/* scalar_float_adder/scalar_float_adder.sv */
/*
 * Scalar float add/subtract, three cycles START to READY
 *   Stage 1 operand capture with subtract sign flip
 *   Stage 2 align/add and special classifier results
 *   Stage 3 normalised or special result
 */

`timescale 1ns/100ps
`default_nettype none

module scalar_float_adder #(
  parameter int EXP_SIZE = float_pkg::exp_size_default,
  parameter int MANT_SIZE = float_pkg::mant_size_default,
  localparam int DATA_SIZE = EXP_SIZE + MANT_SIZE + 1
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  output logic                 READY,
  input  wire                  OPERATION,
  input  wire  [DATA_SIZE-1:0] DATA_A_IN,
  input  wire  [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // One bit per stage with READY on bit 2
  logic [2:0] valid_q;

  // Stage 1
  logic [DATA_SIZE-1:0] a_s1;
  logic [DATA_SIZE-1:0] b_s1;

  // Parallel path outputs
  logic [MANT_SIZE+1:0] sum_mag;
  logic                 sum_sign;
  logic [EXP_SIZE-1:0]  sum_exp;
  logic                 special;
  logic [DATA_SIZE-1:0] special_value;

  // Stage 2
  logic [MANT_SIZE+1:0] sum_mag_s2;
  logic                 sum_sign_s2;
  logic [EXP_SIZE-1:0]  sum_exp_s2;
  logic                 special_s2;
  logic [DATA_SIZE-1:0] special_value_s2;

  logic [DATA_SIZE-1:0] result;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], START};
    end
  end

  always_ff @(posedge CLK) begin
    if (START) begin
      a_s1 <= DATA_A_IN;
      // Subtract is add with B negated
      b_s1 <= {DATA_B_IN[DATA_SIZE-1] ^ OPERATION, DATA_B_IN[DATA_SIZE-2:0]};
    end
    if (valid_q[0]) begin
      sum_mag_s2       <= sum_mag;
      sum_sign_s2      <= sum_sign;
      sum_exp_s2       <= sum_exp;
      special_s2       <= special;
      special_value_s2 <= special_value;
    end
    if (valid_q[1]) begin
      DATA_OUT <= result;
    end
  end

  assign READY = valid_q[2];

  float_align_add #(
    .EXP_SIZE (EXP_SIZE),
    .MANT_SIZE(MANT_SIZE)
  ) float_align_add_inst (
    .a       (a_s1),
    .b       (b_s1),
    .sum_mag (sum_mag),
    .sum_sign(sum_sign),
    .sum_exp (sum_exp),
    .a_zero  (),
    .b_zero  ()
  );

  float_special_case #(
    .EXP_SIZE (EXP_SIZE),
    .MANT_SIZE(MANT_SIZE)
  ) float_special_case_inst (
    .a            (a_s1),
    .b            (b_s1),
    .special      (special),
    .special_value(special_value)
  );

  float_normalize_select #(
    .EXP_SIZE (EXP_SIZE),
    .MANT_SIZE(MANT_SIZE)
  ) float_normalize_select_inst (
    .sum_mag      (sum_mag_s2),
    .sum_sign     (sum_sign_s2),
    .sum_exp      (sum_exp_s2),
    .special      (special_s2),
    .special_value(special_value_s2),
    .result       (result)
  );

endmodule : scalar_float_adder

`default_nettype wire

/* vector_float_adder/vector_float_adder.sv */
/*
 * Vector float add/subtract sequencer
 *   Gathers operand pairs from two strobed streams
 *   Runs one scalar operation per pair, forwards each result
 */

`timescale 1ns/100ps
`default_nettype none

module vector_float_adder #(
  parameter int EXP_SIZE = float_pkg::exp_size_default,
  parameter int MANT_SIZE = float_pkg::mant_size_default,
  parameter int COUNT_SIZE = float_pkg::count_size_default,
  localparam int DATA_SIZE = EXP_SIZE + MANT_SIZE + 1
) (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   START,
  output logic                  READY,
  input  wire                   OPERATION,
  input  wire                   DATA_A_IN_ENABLE,
  input  wire                   DATA_B_IN_ENABLE,
  output logic                  DATA_OUT_ENABLE,
  input  wire  [COUNT_SIZE-1:0] SIZE_IN,
  input  wire  [DATA_SIZE-1:0]  DATA_A_IN,
  input  wire  [DATA_SIZE-1:0]  DATA_B_IN,
  output logic [DATA_SIZE-1:0]  DATA_OUT
);

  import float_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  seq_state_t state_q;

  // Element index and latched vector length
  logic [COUNT_SIZE-1:0] index_q;
  logic [COUNT_SIZE-1:0] count_q;

  // Operand have-flags
  logic have_a;
  logic have_b;
  logic pair_ready;

  // Scalar adder interface
  logic                 scalar_start;
  logic                 scalar_ready;
  logic                 op_q;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic [DATA_SIZE-1:0] scalar_result;

  // Both operands held, hand-off next cycle
  assign pair_ready = have_a & have_b;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q         <= idle;
      index_q         <= '0;
      count_q         <= '0;
      have_a          <= 1'b0;
      have_b          <= 1'b0;
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Strobes default low
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      scalar_start    <= 1'b0;
      case (state_q)
        idle: begin
          if (START) begin
            count_q <= SIZE_IN;
            index_q <= '0;
            have_a  <= 1'b0;
            have_b  <= 1'b0;
            state_q <= gather;
          end
        end
        gather: begin
          if (pair_ready) begin
            // Launch scalar op, flags drop with it
            scalar_start <= 1'b1;
            have_a       <= 1'b0;
            have_b       <= 1'b0;
            state_q      <= wait_result;
          end else begin
            if (DATA_A_IN_ENABLE) have_a <= 1'b1;
            if (DATA_B_IN_ENABLE) have_b <= 1'b1;
          end
        end
        wait_result: begin
          // Input strobes ignored here
          if (scalar_ready) begin
            DATA_OUT        <= scalar_result;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_q == count_q - COUNT_SIZE'(1)) begin
              READY   <= 1'b1;
              state_q <= idle;
            end else begin
              index_q <= index_q + COUNT_SIZE'(1);
              state_q <= gather;
            end
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state_q == gather && !pair_ready) begin
      if (DATA_A_IN_ENABLE) a_q <= DATA_A_IN;
      if (DATA_B_IN_ENABLE) b_q <= DATA_B_IN;
    end
    // Operation sampled once the pair is complete
    if (state_q == gather && pair_ready) begin
      op_q <= OPERATION;
    end
  end

  scalar_float_adder #(
    .EXP_SIZE (EXP_SIZE),
    .MANT_SIZE(MANT_SIZE)
  ) scalar_float_adder_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (scalar_start),
    .READY    (scalar_ready),
    .OPERATION(op_q),
    .DATA_A_IN(a_q),
    .DATA_B_IN(b_q),
    .DATA_OUT (scalar_result)
  );

endmodule : vector_float_adder

`default_nettype wire

/* dv/vector_float_adder_checker.sv */
/*
 * Bound assertions on the vector sequencer strobes
 *   Output strobe width, READY alignment, scalar START pulse
 */

`timescale 1ns/100ps
`default_nettype none

module vector_float_adder_checker (
  input wire CLK,
  input wire RST,
  input wire READY,
  input wire DATA_OUT_ENABLE,
  input wire scalar_start
);

  // One cycle per result, never held
  a_out_enable_pulse : assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE
  ) else $error("DATA_OUT_ENABLE stayed high for two cycles");

  // Last element strobe carries READY
  a_ready_with_data : assert property (
    @(posedge CLK) disable iff (RST) READY |-> DATA_OUT_ENABLE
  ) else $error("READY without DATA_OUT_ENABLE");

  // Only one scalar op in flight
  a_scalar_start_pulse : assert property (
    @(posedge CLK) disable iff (RST) scalar_start |=> !scalar_start
  ) else $error("scalar START longer than one cycle");

endmodule : vector_float_adder_checker

bind vector_float_adder vector_float_adder_checker checker_inst (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
  .scalar_start   (scalar_start)
);

`default_nettype wire

/* dv/vector_float_adder_tb.sv */
/*
 * Testbench for the vector float adder
 *   Clock, reset, xorshift operand generation, reference model
 *   Driver with strobe orderings, comparing process, timeout
 */

`timescale 1ns/100ps
`default_nettype none

module vector_float_adder_tb;

  import float_pkg::*;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam int EXP_W    = exp_size_default;
  localparam int MANT_W   = mant_size_default;
  localparam int CNT_W    = count_size_default;
  localparam int DATA_W   = EXP_W + MANT_W + 1;
  localparam int EXP_ONES = (1 << EXP_W) - 1;

  localparam logic [DATA_W-1:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MANT_W-1){1'b0}}};
  localparam logic [31:0] SEED = 32'h3622_4438;
  localparam int RESET_CYCLES = 16;

  // Operand kinds
  localparam int KIND_NORMAL    = 0;
  localparam int KIND_CLOSE     = 1;
  localparam int KIND_SPECIAL   = 2;
  localparam int KIND_OVERFLOW  = 3;
  localparam int KIND_UNDERFLOW = 4;
  localparam int KIND_MIXED     = 5;

  // Orders 0..3 are fixed and this one rotates per element
  localparam int ORDER_MIX = 4;

  // Lengths 1..8 plus four close, two special, two range and four order vectors
  localparam int TOTAL_ELEMENTS = 36 + 4 * 8 + 2 * 8 + 2 * 8 + 4 * 6;
  localparam int TIMEOUT_CYCLES = TOTAL_ELEMENTS * 20 + 200;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic              CLK;
  logic              RST;
  logic              START;
  logic              READY;
  logic              OPERATION;
  logic              DATA_A_IN_ENABLE;
  logic              DATA_B_IN_ENABLE;
  logic              DATA_OUT_ENABLE;
  logic [CNT_W-1:0]  SIZE_IN;
  logic [DATA_W-1:0] DATA_A_IN;
  logic [DATA_W-1:0] DATA_B_IN;
  logic [DATA_W-1:0] DATA_OUT;

  // Scoreboard state
  logic [DATA_W-1:0] expect_q[$];
  int                len_q[$];
  logic [DATA_W-1:0] expected;
  logic [31:0]       rng_state;
  logic [31:0]       saved_state;
  int                error_count;
  int                out_count;
  int                vec_count;
  int                cycle_count;

  vector_float_adder #(
    .EXP_SIZE  (EXP_W),
    .MANT_SIZE (MANT_W),
    .COUNT_SIZE(CNT_W)
  ) vector_float_adder_inst (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .OPERATION       (OPERATION),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .SIZE_IN         (SIZE_IN),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .DATA_OUT        (DATA_OUT)
  );

  // 4 ns period
  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  ////////////////////////////////////////
  // Random numbers and operands
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [DATA_W-1:0] make_float(input logic s, input int e,
                                                   input logic [MANT_W-1:0] m);
    return {s, EXP_W'(e), m};
  endfunction

  function automatic int exp_of(input logic [DATA_W-1:0] x);
    return int'(x[DATA_W-2 -: EXP_W]);
  endfunction

  // Exponent anywhere in the normal range
  function automatic logic [DATA_W-1:0] gen_normal();
    logic [31:0] r;
    int          e;
    r = next_rand();
    e = 1 + int'(r % (EXP_ONES - 1));
    return make_float(r[31], e, MANT_W'(next_rand()));
  endfunction

  // Zeros, infinities and NaNs mixed in
  function automatic logic [DATA_W-1:0] gen_biased();
    logic [31:0]       r;
    logic [MANT_W-1:0] m;
    r = next_rand();
    m = MANT_W'(next_rand());
    case (r[3:0])
      4'd0, 4'd1: return make_float(r[31], 0, m);
      4'd2: return make_float(r[31], EXP_ONES, '0);
      4'd3: return make_float(r[31], EXP_ONES, m | MANT_W'(1));
      default: return gen_normal();
    endcase
  endfunction

  task automatic gen_pair(input int kind, input int j,
                          output logic [DATA_W-1:0] a, output logic [DATA_W-1:0] b);
    logic [31:0] r;
    int          e;
    r = next_rand();
    case (kind)
      KIND_NORMAL: begin
        a = gen_normal();
        e = exp_of(a) + int'(r[9:8]) - 1;
        if (e < 1) e = 1;
        if (e > EXP_ONES - 1) e = EXP_ONES - 1;
        // Bias toward equal and nearby exponents
        if (r[1:0] == 2'd0) b = make_float(r[31], exp_of(a), MANT_W'(next_rand()));
        else if (r[1:0] == 2'd1) b = make_float(r[31], e, MANT_W'(next_rand()));
        else b = gen_normal();
      end
      KIND_CLOSE: begin
        a = gen_normal();
        e = (exp_of(a) > 1) ? exp_of(a) - 1 : exp_of(a) + 1;
        if (j % 3 == 0) b = a;
        else if (j % 3 == 1) b = a ^ DATA_W'((r % 7) + 1);
        else b = make_float(a[DATA_W-1], e, MANT_W'(next_rand()));
      end
      KIND_SPECIAL: begin
        case (j)
          0: begin
            a = make_float(r[31], EXP_ONES, MANT_W'(next_rand()) | MANT_W'(1));
            b = gen_normal();
          end
          1: begin
            a = make_float(1'b0, EXP_ONES, '0);
            b = make_float(1'b0, EXP_ONES, '0);
          end
          2: begin
            a = make_float(1'b0, EXP_ONES, '0);
            b = gen_normal();
          end
          3: begin
            a = gen_normal();
            b = make_float(1'b1, EXP_ONES, '0);
          end
          4: begin
            a = make_float(r[31], 0, MANT_W'(next_rand()));
            b = gen_normal();
          end
          5: begin
            a = make_float(1'b0, 0, MANT_W'(next_rand()));
            b = make_float(1'b1, 0, MANT_W'(next_rand()));
          end
          6: begin
            a = make_float(1'b1, EXP_ONES, '0);
            b = make_float(1'b0, EXP_ONES, MANT_W'(r) | MANT_W'(1));
          end
          7: begin
            a = make_float(1'b1, EXP_ONES, '0);
            b = make_float(1'b0, EXP_ONES, '0);
          end
          default: begin
            a = gen_biased();
            b = gen_biased();
          end
        endcase
      end
      KIND_OVERFLOW: begin
        // Same sign at the top exponent carries out on every even element
        a = make_float(r[31], EXP_ONES - 1, MANT_W'(next_rand()));
        b = make_float(r[31], EXP_ONES - 1 - (j % 2), MANT_W'(next_rand()));
      end
      KIND_UNDERFLOW: begin
        a = make_float(r[31], 1 + int'(r[5:4] % 3), MANT_W'(next_rand()));
        if (j % 2 == 0) b = a ^ DATA_W'((r % 7) + 1);
        else b = make_float(r[31], exp_of(a), MANT_W'(next_rand()));
      end
      default: begin
        a = gen_biased();
        b = gen_biased();
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [DATA_W-1:0] ref_float_add(input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b_raw,
                                                      input logic sub);
    logic [DATA_W-1:0] b;
    logic              sa;
    logic              sb;
    logic              s_big;
    logic              a_nan;
    logic              b_nan;
    logic              a_inf;
    logic              b_inf;
    int                ea;
    int                eb;
    int                e_big;
    int                e_small;
    int                e_res;
    logic [MANT_W+1:0] ma;
    logic [MANT_W+1:0] mb;
    logic [MANT_W+1:0] m_big;
    logic [MANT_W+1:0] m_small;
    logic [MANT_W+1:0] sum;
    b  = {b_raw[DATA_W-1] ^ sub, b_raw[DATA_W-2:0]};
    sa = a[DATA_W-1];
    sb = b[DATA_W-1];
    ea = exp_of(a);
    eb = exp_of(b);
    a_nan = (ea == EXP_ONES) && (a[MANT_W-1:0] != '0);
    b_nan = (eb == EXP_ONES) && (b[MANT_W-1:0] != '0);
    a_inf = (ea == EXP_ONES) && (a[MANT_W-1:0] == '0);
    b_inf = (eb == EXP_ONES) && (b[MANT_W-1:0] == '0);
    if (a_nan || b_nan) return QNAN;
    if (a_inf && b_inf && (sa != sb)) return QNAN;
    if (a_inf) return {sa, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
    if (b_inf) return {sb, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
    // Zero exponent field is zero
    ma = (ea == 0) ? '0 : {2'b01, a[MANT_W-1:0]};
    mb = (eb == 0) ? '0 : {2'b01, b[MANT_W-1:0]};
    if ((ea > eb) || ((ea == eb) && (ma >= mb))) begin
      s_big = sa;
      e_big = ea;
      e_small = eb;
      m_big = ma;
      m_small = mb;
    end else begin
      s_big = sb;
      e_big = eb;
      e_small = ea;
      m_big = mb;
      m_small = ma;
    end
    // Truncating alignment
    m_small = (e_big - e_small > MANT_W + 1) ? '0 : m_small >> (e_big - e_small);
    sum = (sa == sb) ? m_big + m_small : m_big - m_small;
    if (sum == '0) return '0;
    e_res = e_big;
    if (sum[MANT_W+1]) begin
      sum = sum >> 1;
      e_res++;
    end else begin
      for (int i = 0; i <= MANT_W; i++) begin
        if (!sum[MANT_W]) begin
          sum = sum << 1;
          e_res--;
        end
      end
    end
    if (e_res <= 0) return '0;
    if (e_res >= EXP_ONES) return {s_big, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
    return {s_big, EXP_W'(e_res), sum[MANT_W-1:0]};
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                             input string what);
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t: %s mismatch, got %h expected %h", $time, what, got, want);
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST && DATA_OUT_ENABLE) begin
      out_count++;
      vec_count++;
      if (expect_q.size() == 0) begin
        error_count++;
        $display("Result strobe at %0t with no expected result queued", $time);
      end else begin
        expected = expect_q.pop_front();
        check_value(DATA_OUT, expected, "DATA_OUT");
      end
    end
    if (!RST && READY) begin
      if (len_q.size() == 0) begin
        error_count++;
        $display("READY at %0t with no vector in progress", $time);
      end else begin
        check_value(DATA_W'(vec_count), DATA_W'(len_q.pop_front()), "element count at READY");
      end
      vec_count = 0;
    end
  end

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////

  // Entered and left just after a falling edge
  task automatic drive_pair(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                            input int order, input int j);
    DATA_A_IN = a;
    DATA_B_IN = b;
    case (order)
      0: begin
        DATA_A_IN_ENABLE = 1'b1;
        DATA_B_IN_ENABLE = 1'b1;
        @(negedge CLK);
      end
      1: begin
        DATA_A_IN_ENABLE = 1'b1;
        @(negedge CLK);
        DATA_A_IN_ENABLE = 1'b0;
        DATA_B_IN_ENABLE = 1'b1;
        @(negedge CLK);
      end
      2: begin
        DATA_B_IN_ENABLE = 1'b1;
        @(negedge CLK);
        DATA_B_IN_ENABLE = 1'b0;
        DATA_A_IN_ENABLE = 1'b1;
        @(negedge CLK);
      end
      default: begin
        // Idle gaps before and between strobes
        repeat (j % 4) @(negedge CLK);
        DATA_A_IN_ENABLE = 1'b1;
        @(negedge CLK);
        DATA_A_IN_ENABLE = 1'b0;
        repeat (1 + (j * 3) % 4) @(negedge CLK);
        DATA_B_IN_ENABLE = 1'b1;
        @(negedge CLK);
      end
    endcase
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
  endtask

  task automatic send_vector(input int len, input logic op, input int kind,
                             input int order_mode);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    int                order;
    len_q.push_back(len);
    SIZE_IN   = CNT_W'(len);
    OPERATION = op;
    START     = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    for (int j = 0; j < len; j++) begin
      gen_pair(kind, j, a, b);
      expect_q.push_back(ref_float_add(a, b, op));
      order = (order_mode == ORDER_MIX) ? j % 4 : order_mode;
      drive_pair(a, b, order, j);
      // Next pair only after this result is out
      while (!DATA_OUT_ENABLE) @(negedge CLK);
    end
    @(negedge CLK);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    OPERATION        = 1'b0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    SIZE_IN          = '0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    rng_state        = SEED;
    error_count      = 0;
    out_count        = 0;
    vec_count        = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Addition, lengths 1 to 8
    for (int n = 1; n <= 8; n++) send_vector(n, 1'b0, KIND_NORMAL, ORDER_MIX);
    // Subtraction of equal and near-equal operands
    for (int n = 0; n < 4; n++) send_vector(8, 1'b1, KIND_CLOSE, ORDER_MIX);
    send_vector(8, 1'b0, KIND_SPECIAL, ORDER_MIX);
    send_vector(8, 1'b1, KIND_SPECIAL, ORDER_MIX);
    send_vector(8, 1'b0, KIND_OVERFLOW, ORDER_MIX);
    send_vector(8, 1'b1, KIND_UNDERFLOW, ORDER_MIX);
    // Same operands under every strobe order
    saved_state = rng_state;
    for (int o = 0; o < 4; o++) begin
      rng_state = saved_state;
      send_vector(6, 1'b1, KIND_MIXED, o);
    end

    repeat (4) @(negedge CLK);
    check_value(DATA_W'(out_count), DATA_W'(TOTAL_ELEMENTS), "total result count");
    if (expect_q.size() != 0 || len_q.size() != 0) begin
      error_count++;
      $display("Run ended with %0d results and %0d vectors still outstanding",
               expect_q.size(), len_q.size());
    end
    $display("Checked %0d results, errors: %0d", out_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Cycle limit scaled by element count
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped producing results", cycle_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule : vector_float_adder_tb

`default_nettype wire

/* sim.f */
common/float_pkg.sv
scalar_float_adder/float_align_add.sv
scalar_float_adder/float_special_case.sv
scalar_float_adder/float_normalize_select.sv
scalar_float_adder/scalar_float_adder.sv
vector_float_adder/vector_float_adder.sv
dv/vector_float_adder_checker.sv
dv/vector_float_adder_tb.sv

/* Makefile */
# Verilator simulation of the vector float adder

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vector_float_adder_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
